// File: project.f
+incdir+src
src/cpu_pkg.sv
src/stack_ctrl_if.sv
src/cpu_branch.sv
src/cpu_pshpul.sv
src/cpu_ucode.sv
src/cpu_ctrl.sv
test/cpu_ctrl_tb.sv

// File: run.sh
#!/bin/sh
# build the control unit testbench with Verilator, run it and scan the output
verilator --binary --timing -Wno-fatal -f project.f --top-module cpu_ctrl_tb \
    -o cpu_ctrl_sim \
    && ./obj_dir/cpu_ctrl_sim | tee /dev/stderr | grep -q "NO ERRORS" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// File: src/cpu_branch.sv
// branch condition evaluator
// picks one of eight conditions from the opcode and tests it against cc
`include "cpu_defines.svh"

module cpu_branch (
    input  logic [7:0] op,
    input  logic [7:0] cc,
    output logic       branch
);

    cpu_pkg::op_view_u view;
    logic              flag_c;
    logic              flag_z;
    logic              flag_n;

    assign view.raw = op;
    assign flag_c   = cc[`CC_C];
    assign flag_z   = cc[`CC_Z];
    assign flag_n   = cc[`CC_N];

    always_comb begin
        case (view.br.cond)
            cpu_pkg::COND_ALWAYS: branch = 1'b1;
            cpu_pkg::COND_NEVER:  branch = 1'b0;
            cpu_pkg::COND_EQ:     branch = flag_z;
            cpu_pkg::COND_NE:     branch = !flag_z;
            cpu_pkg::COND_CS:     branch = flag_c;
            cpu_pkg::COND_CC:     branch = !flag_c;
            cpu_pkg::COND_MI:     branch = flag_n;
            cpu_pkg::COND_PL:     branch = !flag_n;
            default:              branch = 1'b0;
        endcase
        // codes 8..F are not in the table
        if (view.br.rsv) begin
            branch = 1'b0;
        end
    end

endmodule

// File: src/cpu_ctrl.sv
// CPU control unit top level
// owns the program counter, decodes register-load strobes and ties the
// microcode sequencer, branch evaluator and stack walker together
`include "cpu_defines.svh"

module cpu_ctrl (
    input  logic        clk,
    input  logic        rst,
    input  logic        cen,
    input  logic [7:0]  op,
    input  logic [15:0] mdata,
    input  logic [7:0]  cc,
    input  logic        mem_busy,
    output logic [15:0] pc,
    output logic        ni,
    output logic        opd,
    output logic        up_a,
    output logic        up_b,
    output logic [7:0]  psh_sel,
    output logic        pul_en,
    output logic        hihalf,
    output logic        stack_busy
);

    logic up_ld8;
    logic set_pc_br8;
    logic set_pc_br16;
    logic pc_jmp;
    logic branch;
    logic br_taken;
    logic bdone;
    logic pul_pc;

    stack_ctrl_if stk_bus ();

    assign up_a = up_ld8 && !op[0];
    assign up_b = up_ld8 && op[0];

    assign psh_sel    = stk_bus.psh_sel;
    assign pul_en     = stk_bus.pul_en;
    assign hihalf     = stk_bus.hihalf;
    assign stack_busy = stk_bus.busy;

    assign br_taken = (set_pc_br8 || set_pc_br16) && branch;
    assign pul_pc   = pul_en && psh_sel[`PSH_PC_BIT];

    always_ff @(posedge clk) begin
        if (rst) begin
            pc    <= 16'd0;
            bdone <= 1'b0;
        end else if (cen) begin
            // held high while mem_busy stretches the BRANCH cycle
            bdone <= set_pc_br8 || set_pc_br16;
            if (opd && !mem_busy) begin
                pc <= pc + 16'd1;
            end else if (br_taken && !bdone) begin
                if (set_pc_br16) begin
                    pc <= pc + mdata;
                end else begin
                    pc <= pc + {{8{mdata[7]}}, mdata[7:0]};
                end
            end else if (pc_jmp) begin
                pc <= mdata;
            end else if (pul_pc) begin
                if (hihalf) begin
                    pc[15:8] <= mdata[7:0];
                end else begin
                    pc[7:0] <= mdata[7:0];
                end
            end
        end
    end

    cpu_ucode u_ucode (
        .clk         (clk),
        .rst         (rst),
        .cen         (cen),
        .mem_busy    (mem_busy),
        .op          (op),
        .mdata       (mdata[7:0]),
        .ni          (ni),
        .opd         (opd),
        .up_ld8      (up_ld8),
        .set_pc_br8  (set_pc_br8),
        .set_pc_br16 (set_pc_br16),
        .pc_jmp      (pc_jmp),
        .stk         (stk_bus.seq)
    );

    cpu_branch u_branch (
        .op     (op),
        .cc     (cc),
        .branch (branch)
    );

    cpu_pshpul u_pshpul (
        .clk      (clk),
        .rst      (rst),
        .cen      (cen),
        .mem_busy (mem_busy),
        .stk      (stk_bus.walker)
    );

endmodule

// File: src/cpu_defines.svh
// opcode values and bit positions for the 8-bit accumulator CPU control unit
// covers the instruction subset sequenced by the microcode
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// single opcodes, accumulator picked by bit 0 on loads
`define OP_NOP      8'h12
`define OP_LDA_IMM  8'h86
`define OP_LDB_IMM  8'h87
`define OP_JMP_EXT  8'h7E
`define OP_PSHS     8'h34
`define OP_PULS     8'h35

// branch classes by upper nibble, condition in the lower one
`define OP_BR8_HI   4'h2
`define OP_BR16_HI  4'hA

// flag positions in the cc byte
`define CC_C        0
`define CC_V        1
`define CC_Z        2
`define CC_N        3

// postbyte bit for PC, bits 7..4 are word registers
`define PSH_PC_BIT  7

`endif

// File: src/cpu_pkg.sv
// shared types for the CPU control unit
// microcode steps, branch conditions and the two-way opcode view
package cpu_pkg;

    // microcode steps walked by the sequencer
    typedef enum logic [2:0] {
        IDLE,
        OPERAND,
        BRANCH,
        JUMP,
        STACK,
        DONE
    } ustep_e;

    // branch conditions, encoded in opcode bits 2..0
    typedef enum logic [2:0] {
        COND_ALWAYS,
        COND_NEVER,
        COND_EQ,
        COND_NE,
        COND_CS,
        COND_CC,
        COND_MI,
        COND_PL
    } cond_e;

    // class nibble plus condition, bit 3 marks codes outside the table
    typedef struct packed {
        logic [3:0] cls;
        logic       rsv;
        cond_e      cond;
    } op_fields_t;

    typedef union packed {
        logic [7:0] raw;
        op_fields_t br;
    } op_view_u;

endpackage

// File: src/cpu_pshpul.sv
// push/pull stack walker
// moves one byte per enabled cycle through the postbyte mask, pushes from
// bit 7 down and pulls from bit 0 up, word registers take two cycles
module cpu_pshpul (
    input  logic         clk,
    input  logic         rst,
    input  logic         cen,
    input  logic         mem_busy,
    stack_ctrl_if.walker stk
);

    logic [7:0] work;
    logic       pull;
    logic       second;
    logic [2:0] sel_idx;
    logic       wide;
    logic       advance;

    assign advance = cen && !mem_busy;

    // highest set bit on push, lowest on pull
    always_comb begin
        sel_idx = 3'd0;
        if (pull) begin
            for (int i = 7; i >= 0; i--) begin
                if (work[i]) begin
                    sel_idx = 3'(i);
                end
            end
        end else begin
            for (int i = 0; i < 8; i++) begin
                if (work[i]) begin
                    sel_idx = 3'(i);
                end
            end
        end
    end

    // PC, U, Y and X sit in the upper half
    assign wide = sel_idx[2];

    assign stk.busy    = |work;
    assign stk.psh_sel = stk.busy ? (8'd1 << sel_idx) : 8'd0;
    assign stk.pul_en  = stk.busy && pull;

    // push goes low then high, pull goes high then low
    assign stk.hihalf  = stk.busy && wide && (pull ? !second : second);

    always_ff @(posedge clk) begin
        if (rst) begin
            work   <= 8'd0;
            pull   <= 1'b0;
            second <= 1'b0;
        end else if (advance) begin
            if (stk.psh_go || stk.pul_go) begin
                work   <= stk.mask;
                pull   <= stk.pul_go;
                second <= 1'b0;
            end else if (stk.busy) begin
                if (wide && !second) begin
                    second <= 1'b1;
                end else begin
                    // last byte of this register moved
                    work[sel_idx] <= 1'b0;
                    second        <= 1'b0;
                end
            end
        end
    end

endmodule

// File: src/cpu_ucode.sv
// microcode sequencer
// decodes the opcode into an entry step, counts operand bytes and
// issues the per-cycle control strobes, stack moves go to the walker
`include "cpu_defines.svh"

module cpu_ucode (
    input  logic       clk,
    input  logic       rst,
    input  logic       cen,
    input  logic       mem_busy,
    input  logic [7:0] op,
    input  logic [7:0] mdata,
    output logic       ni,
    output logic       opd,
    output logic       up_ld8,
    output logic       set_pc_br8,
    output logic       set_pc_br16,
    output logic       pc_jmp,
    stack_ctrl_if.seq  stk
);

    cpu_pkg::op_view_u view;
    cpu_pkg::ustep_e   step;
    cpu_pkg::ustep_e   step_nxt;
    logic [1:0]        left;
    logic [1:0]        left_nxt;
    logic [7:0]        mask_q;
    logic              go_sent;
    logic              advance;
    logic              psh_go;
    logic              pul_go;
    logic              is_ld8;
    logic              is_br8;
    logic              is_br16;
    logic              is_jmp;
    logic              is_pul;
    logic              is_stack;

    assign view.raw = op;
    assign advance  = cen && !mem_busy;

    assign is_ld8   = view.raw == `OP_LDA_IMM || view.raw == `OP_LDB_IMM;
    assign is_br8   = view.br.cls == `OP_BR8_HI;
    assign is_br16  = view.br.cls == `OP_BR16_HI;
    assign is_jmp   = view.raw == `OP_JMP_EXT;
    assign is_pul   = view.raw == `OP_PULS;
    assign is_stack = view.raw == `OP_PSHS || is_pul;

    always_comb begin
        step_nxt    = step;
        left_nxt    = left;
        ni          = 1'b0;
        opd         = 1'b0;
        up_ld8      = 1'b0;
        set_pc_br8  = 1'b0;
        set_pc_br16 = 1'b0;
        pc_jmp      = 1'b0;
        psh_go      = 1'b0;
        pul_go      = 1'b0;
        case (step)
            cpu_pkg::IDLE: begin
                // opcodes outside the subset wait here
                if (view.raw == `OP_NOP) begin
                    ni = 1'b1;
                end else if (is_ld8) begin
                    opd      = 1'b1;
                    up_ld8   = 1'b1;
                    step_nxt = cpu_pkg::DONE;
                end else if (is_br8) begin
                    opd      = 1'b1;
                    step_nxt = cpu_pkg::BRANCH;
                end else if (is_br16 || is_jmp) begin
                    // one more operand byte after this one
                    opd      = 1'b1;
                    left_nxt = 2'd1;
                    step_nxt = cpu_pkg::OPERAND;
                end else if (is_stack) begin
                    // this operand is the register mask
                    opd      = 1'b1;
                    step_nxt = cpu_pkg::STACK;
                end
            end
            cpu_pkg::OPERAND: begin
                opd      = 1'b1;
                left_nxt = left - 2'd1;
                if (left == 2'd1) begin
                    step_nxt = is_jmp ? cpu_pkg::JUMP : cpu_pkg::BRANCH;
                end
            end
            cpu_pkg::BRANCH: begin
                set_pc_br8  = !is_br16;
                set_pc_br16 = is_br16;
                step_nxt    = cpu_pkg::DONE;
            end
            cpu_pkg::JUMP: begin
                pc_jmp   = 1'b1;
                step_nxt = cpu_pkg::DONE;
            end
            cpu_pkg::STACK: begin
                if (!go_sent) begin
                    psh_go = !is_pul;
                    pul_go = is_pul;
                end else if (!stk.busy) begin
                    ni       = 1'b1;
                    step_nxt = cpu_pkg::IDLE;
                end
            end
            cpu_pkg::DONE: begin
                ni       = 1'b1;
                step_nxt = cpu_pkg::IDLE;
            end
            default: step_nxt = cpu_pkg::IDLE;
        endcase
    end

    assign stk.psh_go = psh_go;
    assign stk.pul_go = pul_go;
    assign stk.mask   = mask_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            step    <= cpu_pkg::IDLE;
            left    <= 2'd0;
            go_sent <= 1'b0;
        end else if (advance) begin
            step    <= step_nxt;
            left    <= left_nxt;
            // go fires only in the first STACK cycle
            go_sent <= step == cpu_pkg::STACK;
        end
    end

    always_ff @(posedge clk) begin
        if (advance && step == cpu_pkg::IDLE && is_stack) begin
            mask_q <= mdata;
        end
    end

endmodule

// File: src/stack_ctrl_if.sv
// push/pull control group between the microcode sequencer and the stack walker
// go strobes and mask one way, byte select and status the other
interface stack_ctrl_if;

    logic       psh_go;
    logic       pul_go;
    logic [7:0] mask;
    logic       busy;
    logic       pul_en;
    logic       hihalf;
    logic [7:0] psh_sel;

    modport seq (
        output psh_go, pul_go, mask,
        input  busy
    );

    modport walker (
        input  psh_go, pul_go, mask,
        output busy, pul_en, hihalf, psh_sel
    );

endinterface

// File: test/cpu_ctrl_tb.sv
// testbench for the CPU control unit
// plays memory and datapath from a table of instructions and checks pc,
// operand strobes, load strobes and the stack walk order
`include "cpu_defines.svh"

module cpu_ctrl_tb;

    timeunit 1ns;
    timeprecision 1ps;

    typedef struct {
        logic [7:0]  op;
        logic [15:0] mdata;
        logic [7:0]  cc;
        logic        stall;
        logic [15:0] word;
        int          bytes;
    } entry_t;

    logic        clk;
    logic        rst;
    logic        cen;
    logic [7:0]  op;
    logic [15:0] mdata;
    logic [7:0]  cc;
    logic        mem_busy;
    logic [15:0] pc;
    logic        ni;
    logic        opd;
    logic        up_a;
    logic        up_b;
    logic [7:0]  psh_sel;
    logic        pul_en;
    logic        hihalf;
    logic        stack_busy;

    entry_t      tests[$];
    logic [9:0]  walk_exp[$];
    logic [9:0]  walk_got[$];
    logic [15:0] pc_model;
    int          seed;
    int          errors;
    int          checks;

    cpu_ctrl cpu_ctrl_inst (.*);

    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;
        end
    end

    task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0d ns: %s is %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    // condition table, conditions 0..7 in opcode bits 2..0
    function automatic logic cond_holds(input logic [2:0] cond, input logic [7:0] c);
        case (cond)
            3'd0: return 1'b1;
            3'd1: return 1'b0;
            3'd2: return c[`CC_Z];
            3'd3: return !c[`CC_Z];
            3'd4: return c[`CC_C];
            3'd5: return !c[`CC_C];
            3'd6: return c[`CC_N];
            default: return !c[`CC_N];
        endcase
    endfunction

    function automatic int operand_bytes(input logic [7:0] o);
        if (o == `OP_NOP) begin
            return 0;
        end
        if (o[7:4] == `OP_BR16_HI || o == `OP_JMP_EXT) begin
            return 2;
        end
        return 1;
    endfunction

    function automatic logic [15:0] expect_pc(input entry_t e, input logic [7:0] c,
                                              input logic [15:0] p);
        logic take;
        take = cond_holds(e.op[2:0], c);
        if (e.op == `OP_JMP_EXT) begin
            return e.mdata;
        end
        if (e.op == `OP_PULS && e.mdata[`PSH_PC_BIT]) begin
            return e.word;
        end
        if (e.op[7:4] == `OP_BR8_HI) begin
            return p + 16'd1 + (take ? {{8{e.mdata[7]}}, e.mdata[7:0]} : 16'd0);
        end
        if (e.op[7:4] == `OP_BR16_HI) begin
            return p + 16'd2 + (take ? e.mdata : 16'd0);
        end
        return p + 16'(operand_bytes(e.op));
    endfunction

    // expected {pul_en, hihalf, psh_sel} per stack byte
    task automatic build_walk(input logic [7:0] mask, input logic pull);
        int b;
        walk_exp.delete();
        for (int k = 0; k < 8; k++) begin
            b = pull ? k : 7 - k;
            if (mask[b] && b >= 4) begin
                walk_exp.push_back({pull, pull, 8'(1 << b)});
                walk_exp.push_back({pull, !pull, 8'(1 << b)});
            end else if (mask[b]) begin
                walk_exp.push_back({pull, 1'b0, 8'(1 << b)});
            end
        end
    endtask

    task automatic run_test(input int idx);
        entry_t     e;
        logic [7:0] ccv;
        int         opd_cnt;
        int         stall_cnt;
        int         ua_cnt;
        int         ub_cnt;
        int         err0;
        logic       done;
        e = tests[idx];
        err0 = errors;
        opd_cnt = 0;
        stall_cnt = 0;
        ua_cnt = 0;
        ub_cnt = 0;
        done = 1'b0;
        walk_got.delete();
        // flags under test from the table, the other cc bits random
        ccv = (e.cc & 8'h0D) | (8'($random(seed)) & 8'hF2);
        op = e.op;
        mdata = e.mdata;
        cc = ccv;
        while (!done) begin
            @(negedge clk);
            opd_cnt += int'(opd);
            ua_cnt += int'(up_a);
            ub_cnt += int'(up_b);
            if (stack_busy) begin
                walk_got.push_back({pul_en, hihalf, psh_sel});
            end
            done = ni;
            @(posedge clk);
            #5;
            // two stalled cycles right after the last operand byte
            mem_busy = e.stall && opd_cnt == operand_bytes(e.op) && stall_cnt < 2;
            if (mem_busy) begin
                stall_cnt++;
            end
            // memory returns the pulled PC bytes
            if (pul_en && psh_sel[`PSH_PC_BIT]) begin
                mdata = {8'h00, hihalf ? e.word[15:8] : e.word[7:0]};
            end
        end
        pc_model = expect_pc(e, ccv, pc_model);
        check("pc", pc, pc_model);
        check("operand strobes", opd_cnt, operand_bytes(e.op));
        check("up_a pulses", ua_cnt, e.op == `OP_LDA_IMM);
        check("up_b pulses", ub_cnt, e.op == `OP_LDB_IMM);
        build_walk(e.mdata[7:0], e.op == `OP_PULS);
        if (e.op != `OP_PSHS && e.op != `OP_PULS) begin
            walk_exp.delete();
        end
        check("stack_busy cycles", walk_got.size(), e.bytes);
        for (int k = 0; k < walk_exp.size() && k < walk_got.size(); k++) begin
            check($sformatf("stack byte %0d pul_en/hihalf/psh_sel", k),
                  walk_got[k], walk_exp[k]);
        end
        $display("test %0d op %02h: %s", idx + 1, e.op, errors == err0 ? "ok" : "failed");
    endtask

    initial begin
        seed = 32'h787023f9;
        errors = 0;
        checks = 0;
        pc_model = 16'd0;
        rst = 1'b1;
        cen = 1'b1;
        op = 8'h01;
        mdata = 16'd0;
        cc = 8'd0;
        mem_busy = 1'b0;
        // op, mdata, cc flags, stall, pulled pc word, stack bytes
        tests.push_back('{`OP_NOP, 16'h0000, 8'h00, 1'b0, 16'h0000, 0});
        tests.push_back('{`OP_LDA_IMM, 16'h0042, 8'h00, 1'b0, 16'h0000, 0});
        tests.push_back('{`OP_LDB_IMM, 16'h0017, 8'h00, 1'b0, 16'h0000, 0});
        tests.push_back('{8'h20, 16'h0010, 8'h00, 1'b0, 16'h0000, 0});
        tests.push_back('{8'h21, 16'h0010, 8'h00, 1'b0, 16'h0000, 0});
        tests.push_back('{8'h22, 16'h55F0, 8'h04, 1'b0, 16'h0000, 0});
        tests.push_back('{8'h23, 16'h0030, 8'h04, 1'b0, 16'h0000, 0});
        tests.push_back('{8'h24, 16'h0080, 8'h01, 1'b0, 16'h0000, 0});
        tests.push_back('{8'h25, 16'h007F, 8'h00, 1'b0, 16'h0000, 0});
        tests.push_back('{8'h26, 16'h00FE, 8'h08, 1'b0, 16'h0000, 0});
        tests.push_back('{8'h27, 16'h0040, 8'h08, 1'b0, 16'h0000, 0});
        tests.push_back('{8'hA0, 16'h1234, 8'h00, 1'b0, 16'h0000, 0});
        tests.push_back('{8'hA1, 16'h1000, 8'h00, 1'b0, 16'h0000, 0});
        tests.push_back('{8'hA2, 16'h2000, 8'h00, 1'b0, 16'h0000, 0});
        tests.push_back('{8'hA3, 16'hFF00, 8'h00, 1'b0, 16'h0000, 0});
        tests.push_back('{8'hA4, 16'h0300, 8'h00, 1'b0, 16'h0000, 0});
        tests.push_back('{8'hA5, 16'h0300, 8'h01, 1'b0, 16'h0000, 0});
        tests.push_back('{8'hA6, 16'h0500, 8'h00, 1'b0, 16'h0000, 0});
        tests.push_back('{8'hA7, 16'h0100, 8'h00, 1'b0, 16'h0000, 0});
        tests.push_back('{`OP_JMP_EXT, 16'h4321, 8'h00, 1'b0, 16'h0000, 0});
        tests.push_back('{`OP_PSHS, 16'h00FF, 8'h00, 1'b0, 16'h0000, 12});
        tests.push_back('{`OP_PSHS, 16'h0081, 8'h00, 1'b0, 16'h0000, 3});
        tests.push_back('{`OP_PSHS, 16'h0016, 8'h00, 1'b0, 16'h0000, 4});
        tests.push_back('{`OP_PULS, 16'h000A, 8'h00, 1'b0, 16'h0000, 2});
        tests.push_back('{`OP_PULS, 16'h0085, 8'h00, 1'b0, 16'hBEEF, 4});
        tests.push_back('{`OP_PULS, 16'h00C0, 8'h00, 1'b0, 16'h1357, 4});
        tests.push_back('{8'h22, 16'h00FC, 8'h04, 1'b1, 16'h0000, 0});
        tests.push_back('{8'hA0, 16'h0200, 8'h00, 1'b1, 16'h0000, 0});
        repeat (2) @(posedge clk);
        #5;
        rst = 1'b0;
        @(negedge clk);
        check("pc after reset", pc, 0);
        check("ni after reset", ni, 0);
        check("opd after reset", opd, 0);
        check("stack_busy after reset", stack_busy, 0);
        check("psh_sel after reset", psh_sel, 0);
        $display("reset: %s", errors == 0 ? "ok" : "failed");
        @(posedge clk);
        #5;
        for (int i = 0; i < tests.size(); i++) begin
            run_test(i);
        end
        $display("%0d tests, %0d checks, %0d errors", tests.size(), checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    // watchdog, 40 cycles per table entry
    initial begin
        #1;
        repeat (tests.size() * 40) @(posedge clk);
        $display("timeout: ni never came within %0d cycles", tests.size() * 40);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule
